// File: logic/versat_pkg.sv
package versat_pkg;

   // datapath and host widths
   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 8;
   localparam int N_STAGE   = 2;
   localparam int MEM_DEPTH = 8;
   localparam int MEM_AW    = 3;

   // local address seen by one stage, bits 3..0 of the host address
   localparam int LOC_AW = 4;

   // host address map
   localparam int         REGION_HI    = 7;
   localparam int         REGION_LO    = 6;
   localparam logic [1:0] REGION_STAGE = 2'd0;
   localparam logic [1:0] REGION_RUN   = 2'd1;
   localparam int         STAGE_BIT    = 4;
   localparam int         MEM_SEL_BIT  = 3;

   // configuration register indices
   localparam logic [2:0] REG_SRC_START = 3'd0;
   localparam logic [2:0] REG_COUNT     = 3'd1;
   localparam logic [2:0] REG_OP        = 3'd2;
   localparam logic [2:0] REG_DST_START = 3'd3;
   localparam logic [2:0] REG_STATUS    = 3'd7;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [MEM_AW-1:0] maddr_t;
   typedef logic [3:0]        count_t;
   typedef logic [1:0]        op_t;

   // own word combined with upstream word
   localparam op_t OP_ADD = 2'd0;
   localparam op_t OP_SUB = 2'd1;
   localparam op_t OP_AND = 2'd2;
   localparam op_t OP_XOR = 2'd3;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DRAIN
   } run_state_e;

endpackage

// File: logic/stage_mem.sv
`timescale 1ns/1ps

module stage_mem
   import versat_pkg::*;
(
   input  logic   clk,

   // host port, used while the stage is idle
   input  logic   host_en,
   input  logic   host_we,
   input  maddr_t host_addr,
   input  data_t  host_wdata,
   output data_t  host_rdata,

   // run read port
   input  maddr_t start,
   input  logic   load,
   input  logic   rd_en,
   output data_t  rd_data,

   // run write port
   input  logic   wr_en,
   input  maddr_t wr_addr,
   input  data_t  wr_data
);

   data_t  mem [MEM_DEPTH];

   // registered read address shared by host and run reads
   maddr_t raddr_q;
   data_t  word;

   // run writes win, host writes never overlap a run
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end else if (host_en && host_we) begin
         mem[host_addr] <= host_wdata;
      end
   end

   // address generator
   always_ff @(posedge clk) begin
      if (load) begin
         raddr_q <= start;
      end else if (rd_en) begin
         raddr_q <= maddr_t'(raddr_q + 1'b1);
      end else if (host_en && !host_we) begin
         raddr_q <= host_addr;
      end
   end

   assign word = mem[raddr_q];

   assign host_rdata = word;

   // no item issued means a zero word on the run side
   assign rd_data = rd_en ? word : '0;

endmodule

// File: logic/stage_alu.sv
`timescale 1ns/1ps

module stage_alu
   import versat_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  logic   in_valid,
   input  op_t    op,
   input  data_t  own,
   input  data_t  upstream,
   input  maddr_t dst_start,
   input  logic   load,
   output logic   wr_en,
   output maddr_t wr_addr,
   output data_t  wr_data
);

   data_t result;

   always_comb begin
      case (op)
         OP_ADD:  result = own + upstream;
         OP_SUB:  result = own - upstream;
         OP_AND:  result = own & upstream;
         OP_XOR:  result = own ^ upstream;
         default: result = '0;
      endcase
   end

   // result lands one cycle after the operands
   always_ff @(posedge clk) begin
      if (in_valid) begin
         wr_data <= result;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= in_valid;
      end
   end

   // write address steps once per delivered result
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_addr <= '0;
      end else if (load) begin
         wr_addr <= dst_start;
      end else if (wr_en) begin
         wr_addr <= maddr_t'(wr_addr + 1'b1);
      end
   end

endmodule

// File: logic/versat_stage.sv
`timescale 1ns/1ps

module versat_stage
   import versat_pkg::*;
(
   input  logic              clk,
   input  logic              rst,

   // host side
   input  logic              valid,
   input  logic              we,
   input  logic [LOC_AW-1:0] addr,
   input  data_t             rdata,
   input  logic              run,
   output data_t             wdata,
   output logic              done,

   // ring side
   input  data_t             flow_in,
   output data_t             flow_out
);

   // configuration registers
   maddr_t     src_start;
   count_t     count;
   op_t        op;
   maddr_t     dst_start;

   run_state_e state;
   count_t     issued;
   logic       start;
   logic       rd_en;
   logic       drained;
   logic       item_valid;

   maddr_t     idx;
   logic       cfg_sel;
   logic       mem_host_en;
   data_t      reg_word;
   data_t      reg_rdata_q;
   logic       mem_sel_q;

   data_t      mem_rdata;
   data_t      mem_host_rdata;
   logic       alu_wr_en;
   maddr_t     alu_wr_addr;
   data_t      alu_wr_data;

   assign idx         = addr[MEM_AW-1:0];
   assign mem_host_en = valid & addr[MEM_SEL_BIT];
   assign cfg_sel     = valid & ~addr[MEM_SEL_BIT];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         src_start <= '0;
         count     <= '0;
         op        <= OP_ADD;
         dst_start <= '0;
      end else if (cfg_sel && we) begin
         case (idx)
            REG_SRC_START: src_start <= maddr_t'(rdata);
            REG_COUNT:     count     <= count_t'(rdata);
            REG_OP:        op        <= op_t'(rdata);
            REG_DST_START: dst_start <= maddr_t'(rdata);
            default:       ;
         endcase
      end
   end

   // host read of a register or the status word
   always_comb begin
      case (idx)
         REG_SRC_START: reg_word = data_t'(src_start);
         REG_COUNT:     reg_word = data_t'(count);
         REG_OP:        reg_word = data_t'(op);
         REG_DST_START: reg_word = data_t'(dst_start);
         REG_STATUS:    reg_word = data_t'(done);
         default:       reg_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (cfg_sel && !we) begin
         reg_rdata_q <= reg_word;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_sel_q <= 1'b0;
      end else if (valid) begin
         mem_sel_q <= addr[MEM_SEL_BIT];
      end
   end

   // memory word comes from the mem read path one cycle after the request
   assign wdata = mem_sel_q ? mem_host_rdata : reg_rdata_q;

   // run controller
   assign start   = (state == IDLE) && run && (count != '0);
   assign rd_en   = (state == RUN);
   assign drained = !item_valid && !alu_wr_en;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state  <= IDLE;
         issued <= '0;
         done   <= 1'b1;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state  <= RUN;
                  issued <= '0;
                  done   <= 1'b0;
               end
            end
            RUN: begin
               issued <= count_t'(issued + 1'b1);
               if (issued == count_t'(count - 1'b1)) begin
                  state <= DRAIN;
               end
            end
            DRAIN: begin
               // wait for the last write to leave the ALU
               if (drained) begin
                  state <= IDLE;
                  done  <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // flow register, zero when no read was issued
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         item_valid <= 1'b0;
         flow_out   <= '0;
      end else begin
         item_valid <= rd_en;
         flow_out   <= mem_rdata;
      end
   end

   stage_mem u_mem (
      .clk        (clk),
      .host_en    (mem_host_en),
      .host_we    (we),
      .host_addr  (idx),
      .host_wdata (rdata),
      .host_rdata (mem_host_rdata),
      .start      (src_start),
      .load       (start),
      .rd_en      (rd_en),
      .rd_data    (mem_rdata),
      .wr_en      (alu_wr_en),
      .wr_addr    (alu_wr_addr),
      .wr_data    (alu_wr_data)
   );

   stage_alu u_alu (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (item_valid),
      .op        (op),
      .own       (flow_out),
      .upstream  (flow_in),
      .dst_start (dst_start),
      .load      (start),
      .wr_en     (alu_wr_en),
      .wr_addr   (alu_wr_addr),
      .wr_data   (alu_wr_data)
   );

endmodule

// File: logic/versat_top.sv
`timescale 1ns/1ps

module versat_top
   import versat_pkg::*;
(
   input  logic  clk,
   input  logic  rst,

   // host port
   input  logic  valid,
   input  addr_t addr,
   input  logic  we,
   input  data_t rdata,
   output logic  ready,
   output data_t wdata
);

   logic [1:0]         region;
   logic               run;
   logic [N_STAGE-1:0] stage_valid;
   logic [N_STAGE-1:0] done;
   data_t              stage_wdata [N_STAGE];

   // flow word leaving each stage
   data_t              flow [N_STAGE];

   // read select captured in the valid cycle
   logic               rd_q;
   logic [1:0]         rd_region_q;
   logic               rd_stage_q;

   assign region = addr[REGION_HI:REGION_LO];

   // a write to the run address starts all stages together
   assign run = valid & we & (region == REGION_RUN);

   always_comb begin
      for (int j = 0; j < N_STAGE; j++) begin
         stage_valid[j] = valid && (region == REGION_STAGE) && (addr[STAGE_BIT] == 1'(j));
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready       <= 1'b0;
         rd_q        <= 1'b0;
         rd_region_q <= '0;
         rd_stage_q  <= 1'b0;
      end else begin
         ready <= valid;
         rd_q  <= valid & ~we;
         if (valid) begin
            rd_region_q <= region;
            rd_stage_q  <= addr[STAGE_BIT];
         end
      end
   end

   // read data in the ready cycle, zero otherwise
   always_comb begin
      wdata = '0;
      if (rd_q) begin
         case (rd_region_q)
            REGION_STAGE: wdata = stage_wdata[rd_stage_q];
            REGION_RUN:   wdata = data_t'(&done);
            default:      wdata = '0;
         endcase
      end
   end

   // stages in a ring, each fed by its upstream neighbour
   for (genvar i = 0; i < N_STAGE; i++) begin : g_stage
      versat_stage u_stage (
         .clk      (clk),
         .rst      (rst),
         .valid    (stage_valid[i]),
         .we       (we),
         .addr     (addr[LOC_AW-1:0]),
         .rdata    (rdata),
         .run      (run),
         .wdata    (stage_wdata[i]),
         .done     (done[i]),
         .flow_in  (flow[(i + N_STAGE - 1) % N_STAGE]),
         .flow_out (flow[i])
      );
   end

endmodule

// File: bench/versat_tb.sv
`timescale 1ns/1ps

module versat_tb
   import versat_pkg::*;
();

   localparam int    CLK_PERIOD = 40;
   // the full test sequence takes roughly a thousand cycles
   localparam int    MAX_CYCLES = 3000;
   localparam int    POLL_LIMIT = 20;
   localparam addr_t RUN_ADDR   = 8'h40;

   logic   clk;
   logic   rst;
   logic   valid;
   addr_t  addr;
   logic   we;
   data_t  rdata;
   logic   ready;
   data_t  wdata;

   integer seed;
   int     cycles = 0;

   // expected memory contents and stage configuration
   data_t  mem_model [N_STAGE][MEM_DEPTH];
   maddr_t cfg_src [N_STAGE];
   count_t cfg_cnt [N_STAGE];
   op_t    cfg_op [N_STAGE];
   maddr_t cfg_dst [N_STAGE];

   versat_top DUT (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .we    (we),
      .rdata (rdata),
      .ready (ready),
      .wdata (wdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         fail_now("timeout, the run went past the cycle limit");
      end
   end

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         fail_now($sformatf("Mismatch at %0d ns: %s expected %h, actual %h",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_now($sformatf("Mismatch at %0d ns: %s expected %b, actual %b",
                            $time, name, exp, act));
      end
   endtask

   function automatic int unsigned rand_below(input int unsigned n);
      logic [31:0] r;
      r = $random(seed);
      return r % n;
   endfunction

   function automatic addr_t reg_addr(input int s, input logic [2:0] idx);
      return {2'b00, 1'b0, 1'(s), 1'b0, idx};
   endfunction

   function automatic addr_t mem_addr(input int s, input int w);
      return {2'b00, 1'b0, 1'(s), 1'b1, 3'(w)};
   endfunction

   // own word combined with the upstream word
   function automatic data_t apply_op(input op_t op, input data_t own, input data_t up);
      case (op)
         OP_ADD:  return own + up;
         OP_SUB:  return own - up;
         OP_AND:  return own & up;
         default: return own ^ up;
      endcase
   endfunction

   // one valid cycle with ready exactly one cycle later
   task automatic host_access(input addr_t a, input logic w, input data_t d,
                              output data_t q);
      @(posedge clk);
      #1;
      valid = 1'b1;
      addr  = a;
      we    = w;
      rdata = d;
      @(negedge clk);
      check_bit("ready", 1'b0, ready);
      @(posedge clk);
      #1;
      valid = 1'b0;
      we    = 1'b0;
      addr  = '0;
      rdata = '0;
      @(negedge clk);
      check_bit("ready", 1'b1, ready);
      q = wdata;
   endtask

   task automatic host_write(input addr_t a, input data_t d);
      data_t q;
      host_access(a, 1'b1, d, q);
      check_data("wdata", '0, q);
   endtask

   task automatic host_read(input addr_t a, output data_t q);
      host_access(a, 1'b0, '0, q);
   endtask

   task automatic expect_read(input addr_t a, input data_t exp, input string name);
      data_t q;
      host_read(a, q);
      check_data(name, exp, q);
   endtask

   task automatic write_mem(input int s, input int w, input data_t d);
      host_write(mem_addr(s, w), d);
      mem_model[s][w] = d;
   endtask

   task automatic fill_random();
      for (int s = 0; s < N_STAGE; s++) begin
         for (int w = 0; w < MEM_DEPTH; w++) begin
            write_mem(s, w, data_t'($random(seed)));
         end
      end
   endtask

   task automatic configure(input int s, input maddr_t src, input count_t cnt,
                            input op_t op, input maddr_t dst);
      host_write(reg_addr(s, REG_SRC_START), data_t'(src));
      host_write(reg_addr(s, REG_COUNT), data_t'(cnt));
      host_write(reg_addr(s, REG_OP), data_t'(op));
      host_write(reg_addr(s, REG_DST_START), data_t'(dst));
      cfg_src[s] = src;
      cfg_cnt[s] = cnt;
      cfg_op[s]  = op;
      cfg_dst[s] = dst;
   endtask

   // ring rule with a zero upstream word once the neighbour has no item left
   task automatic predict_run();
      data_t snap [N_STAGE][MEM_DEPTH];
      data_t own;
      data_t up;
      int    u;
      snap = mem_model;
      for (int s = 0; s < N_STAGE; s++) begin
         u = (s + N_STAGE - 1) % N_STAGE;
         for (int k = 0; k < int'(cfg_cnt[s]); k++) begin
            own = snap[s][maddr_t'(cfg_src[s] + k)];
            up  = (k < int'(cfg_cnt[u])) ? snap[u][maddr_t'(cfg_src[u] + k)] : '0;
            mem_model[s][maddr_t'(cfg_dst[s] + k)] = apply_op(cfg_op[s], own, up);
         end
      end
   endtask

   task automatic run_and_wait();
      data_t q;
      logic  busy;
      int    polls;
      busy = (cfg_cnt[0] != '0) || (cfg_cnt[1] != '0);
      host_write(RUN_ADDR, data_t'(1));
      // first poll lands while any nonzero count is still running
      host_read(RUN_ADDR, q);
      check_data("run_done", data_t'(!busy), q);
      polls = 1;
      while (q !== data_t'(1)) begin
         if (polls >= POLL_LIMIT) begin
            fail_now("run did not report done within the poll limit");
         end
         host_read(RUN_ADDR, q);
         polls++;
      end
      predict_run();
   endtask

   task automatic check_memories();
      for (int s = 0; s < N_STAGE; s++) begin
         for (int w = 0; w < MEM_DEPTH; w++) begin
            expect_read(mem_addr(s, w), mem_model[s][w], $sformatf("stage%0d mem[%0d]", s, w));
         end
      end
   endtask

   task automatic test_reset();
      check_bit("ready", 1'b0, ready);
      check_data("wdata", '0, wdata);
      for (int s = 0; s < N_STAGE; s++) begin
         for (int r = 0; r < 4; r++) begin
            expect_read(reg_addr(s, 3'(r)), '0, $sformatf("stage%0d reg%0d", s, r));
         end
         expect_read(reg_addr(s, REG_STATUS), data_t'(1), "status");
      end
      expect_read(RUN_ADDR, data_t'(1), "run_done");
   endtask

   task automatic test_access();
      maddr_t src;
      count_t cnt;
      op_t    op;
      maddr_t dst;
      fill_random();
      check_memories();
      for (int s = 0; s < N_STAGE; s++) begin
         src = maddr_t'(rand_below(8));
         cnt = count_t'(rand_below(9));
         op  = op_t'(rand_below(4));
         dst = maddr_t'(rand_below(8));
         configure(s, src, cnt, op, dst);
         expect_read(reg_addr(s, REG_SRC_START), data_t'(src), "src_start");
         expect_read(reg_addr(s, REG_COUNT), data_t'(cnt), "count");
         expect_read(reg_addr(s, REG_OP), data_t'(op), "op");
         expect_read(reg_addr(s, REG_DST_START), data_t'(dst), "dst_start");
      end
      expect_read(8'h80, '0, "unused region 2");
      expect_read(8'hC8, '0, "unused region 3");
   endtask

   // count 8 covers the whole memory so results go back in place
   task automatic test_ring_add();
      fill_random();
      configure(0, 3'd0, 4'd8, OP_ADD, 3'd0);
      configure(1, 3'd0, 4'd8, OP_ADD, 3'd0);
      run_and_wait();
      check_memories();
   endtask

   task automatic test_opcodes();
      op_t ops [3];
      ops = '{OP_SUB, OP_AND, OP_XOR};
      for (int i = 0; i < 3; i++) begin
         fill_random();
         configure(0, maddr_t'(i), 4'd4, ops[i], maddr_t'(i + 4));
         configure(1, maddr_t'(i + 2), 4'd4, ops[i], maddr_t'(i + 6));
         run_and_wait();
         check_memories();
      end
   endtask

   task automatic test_unequal();
      fill_random();
      configure(0, 3'd0, 4'd8, OP_ADD, 3'd0);
      configure(1, 3'd0, 4'd3, OP_XOR, 3'd4);
      run_and_wait();
      check_memories();
   endtask

   task automatic test_random();
      count_t cnt;
      maddr_t src;
      maddr_t dst;
      for (int r = 0; r < 4; r++) begin
         fill_random();
         for (int s = 0; s < N_STAGE; s++) begin
            cnt = count_t'(rand_below(5));
            src = maddr_t'(rand_below(8));
            // gap after the source block keeps both blocks apart
            dst = maddr_t'(int'(src) + int'(cnt) + int'(rand_below(9 - 2 * int'(cnt))));
            configure(s, src, cnt, op_t'(rand_below(4)), dst);
         end
         run_and_wait();
         check_memories();
      end
   endtask

   initial begin
      seed  = 32'h8656;
      clk   = 1'b0;
      rst   = 1'b1;
      // a host read held through reset must leave no response behind
      valid = 1'b1;
      addr  = RUN_ADDR;
      we    = 1'b0;
      rdata = '0;
      repeat (2) @(posedge clk);
      #1;
      rst   = 1'b0;
      valid = 1'b0;
      addr  = '0;
      @(negedge clk);
      test_reset();
      test_access();
      test_ring_add();
      test_opcodes();
      test_unequal();
      test_random();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: all.f
logic/versat_pkg.sv
logic/stage_mem.sv
logic/stage_alu.sv
logic/versat_stage.sv
logic/versat_top.sv
bench/versat_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   --top-module versat_tb \
   -f all.f \
   -o versat_sim

# a failing check ends the run with $fatal and a nonzero status
./obj_dir/versat_sim
